// ==== design/huffman_sym_pkg.sv ====
package huffman_sym_pkg;

	// Symbols 1 to 6; the sort network and the FSM are sized for six
	localparam int NUM_SYMBOLS = 6;

	// Occurrence count, wraps at 255
	typedef logic [7:0] count_t;

	// Bit i stands for symbol i+1
	typedef logic [NUM_SYMBOLS-1:0] sym_set_t;

	// One entry of the sort list
	typedef struct packed {
		count_t   count;
		sym_set_t members;
	} item_t;

	// The last two active items, a is second-to-last and b is last
	typedef struct packed {
		item_t a;
		item_t b;
	} item_pair_t;

	typedef struct packed {
		logic [7:0] hc;
		logic [7:0] mask;
	} code_t;

	// Element i belongs to symbol i+1
	typedef count_t [NUM_SYMBOLS-1:0] counts_t;
	typedef code_t [NUM_SYMBOLS-1:0] codes_t;

endpackage

// ==== design/huffman_ctrl_pkg.sv ====
package huffman_ctrl_pkg;

	typedef enum logic [2:0] {
		WAIT,
		COUNTING,
		COUNT_RESULT,
		SORTING,
		MERGE,
		SETUP,
		RESULT
	} state_t;

	// Number of active items in the sort list, 1 to 6
	typedef logic [2:0] slot_t;

	// Sorter command
	// load refills the list from the counts, update writes back a merge
	typedef struct packed {
		logic  load;
		logic  update;
		slot_t num;
	} sort_cmd_t;

endpackage

// ==== design/symbol_counter.sv ====
`timescale 1ns/1ps

module symbol_counter #(
	parameter logic [7:0] SYM_BASE = 8'd1
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     count_en,
	input  logic [7:0]               gray_data,
	output huffman_sym_pkg::counts_t counts
);

	import huffman_sym_pkg::*;

	logic [7:0] gray_q;
	logic [7:0] offset;
	logic       is_symbol;

	// Input register, counted one cycle later
	always_ff @(posedge clk) begin
		gray_q <= gray_data;
	end

	// Distance from symbol 1, wraps below the base so those values fall out too
	assign offset    = gray_q - SYM_BASE;
	assign is_symbol = (offset < 8'(NUM_SYMBOLS));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			counts <= '0;
		end else if (count_en && is_symbol) begin
			counts[offset[2:0]] <= counts[offset[2:0]] + 8'd1;
		end
	end

endmodule

// ==== design/transposition_sorter.sv ====
`timescale 1ns/1ps

module transposition_sorter (
	input  logic                         clk,
	input  logic                         rst,
	input  huffman_ctrl_pkg::sort_cmd_t  sort_cmd,
	input  huffman_sym_pkg::counts_t     counts,
	output logic                         sorted,
	output huffman_sym_pkg::item_pair_t  pair
);

	import huffman_sym_pkg::*;
	import huffman_ctrl_pkg::*;

	// Index 0 holds the largest count once sorted
	item_t [NUM_SYMBOLS-1:0] items;
	item_t [NUM_SYMBOLS-1:0] items_mid;
	item_t [NUM_SYMBOLS-1:0] items_next;
	slot_t                   num_q;
	slot_t                   next_num;
	item_t                   merged;

	// One pass per cycle: odd layer (0,1)(2,3)(4,5) then even layer (1,2)(3,4)
	// Strict less-than keeps equal counts in their order
	always_comb begin
		items_mid = items;
		for (int i = 0; i < NUM_SYMBOLS - 1; i += 2) begin
			if (i + 1 < num_q && items[i].count < items[i+1].count) begin
				items_mid[i]   = items[i+1];
				items_mid[i+1] = items[i];
			end
		end
		items_next = items_mid;
		for (int i = 1; i < NUM_SYMBOLS - 1; i += 2) begin
			if (i + 1 < num_q && items_mid[i].count < items_mid[i+1].count) begin
				items_next[i]   = items_mid[i+1];
				items_next[i+1] = items_mid[i];
			end
		end
	end

	// A pass that moves nothing means the list is in order
	assign sorted = !sort_cmd.load && (items_next == items);

	// Last two active items
	always_comb begin
		pair = '0;
		for (int i = 0; i < NUM_SYMBOLS - 1; i++) begin
			if (i + 2 == num_q) begin
				pair.a = items[i];
				pair.b = items[i+1];
			end
		end
	end

	assign merged.count   = pair.a.count + pair.b.count;
	assign merged.members = pair.a.members | pair.b.members;

	// After a merge the list is one shorter
	assign next_num = sort_cmd.num - 3'd1;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			items <= '0;
			num_q <= slot_t'(NUM_SYMBOLS);
		end else if (sort_cmd.load) begin
			num_q <= sort_cmd.num;
			for (int i = 0; i < NUM_SYMBOLS; i++) begin
				items[i].count   <= counts[i];
				items[i].members <= sym_set_t'(1 << i);
			end
		end else if (sort_cmd.update) begin
			num_q <= next_num;
			// Merged pair takes the new last slot
			for (int i = 0; i < NUM_SYMBOLS; i++) begin
				if (i == next_num - 1) begin
					items[i] <= merged;
				end else begin
					items[i] <= items_next[i];
				end
			end
		end else begin
			items <= items_next;
		end
	end

endmodule

// ==== design/code_builder.sv ====
`timescale 1ns/1ps

module code_builder (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        merge_en,
	input  huffman_sym_pkg::item_pair_t pair,
	output huffman_sym_pkg::codes_t     codes
);

	import huffman_sym_pkg::*;

	// Bit at the current code length, masks are always 0..01..1
	function automatic logic [7:0] next_bit(input logic [7:0] mask);
		return ~mask & {mask[6:0], 1'b1};
	endfunction

	logic [NUM_SYMBOLS-1:0] in_a;
	logic [NUM_SYMBOLS-1:0] in_b;

	assign in_a = pair.a.members;
	assign in_b = pair.b.members;

	// Members of a get a 0, members of b get a 1
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			codes <= '0;
		end else if (merge_en) begin
			for (int j = 0; j < NUM_SYMBOLS; j++) begin
				if (in_a[j] || in_b[j]) begin
					codes[j].mask <= {codes[j].mask[6:0], 1'b1};
				end
				if (in_b[j]) begin
					codes[j].hc <= codes[j].hc | next_bit(codes[j].mask);
				end
			end
		end
	end

endmodule

// ==== design/huffman_control.sv ====
`timescale 1ns/1ps

module huffman_control (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        gray_valid,
	input  logic                        sorted,
	output logic                        count_en,
	output logic                        cnt_valid,
	output huffman_ctrl_pkg::sort_cmd_t sort_cmd,
	output logic                        merge_en,
	output logic                        code_valid
);

	import huffman_sym_pkg::*;
	import huffman_ctrl_pkg::*;

	state_t state;
	state_t state_next;
	slot_t  num_q;

	always_comb begin
		state_next = state;
		case (state)
			WAIT: begin
				if (gray_valid) begin
					state_next = COUNTING;
				end
			end
			COUNTING: begin
				if (!gray_valid) begin
					state_next = COUNT_RESULT;
				end
			end
			COUNT_RESULT: state_next = SORTING;
			SORTING: begin
				if (sorted) begin
					state_next = MERGE;
				end
			end
			// Two items left means this merge was the root
			MERGE:   state_next = (num_q > 3'd2) ? SETUP : RESULT;
			SETUP:   state_next = SORTING;
			RESULT:  state_next = WAIT;
			default: state_next = WAIT;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= WAIT;
			num_q <= slot_t'(NUM_SYMBOLS);
		end else begin
			state <= state_next;
			if (state == SETUP) begin
				num_q <= num_q - 3'd1;
			end else if (state == RESULT) begin
				num_q <= slot_t'(NUM_SYMBOLS);
			end
		end
	end

	// Decoded straight from the state
	assign count_en        = (state == COUNTING);
	assign cnt_valid       = (state == COUNT_RESULT);
	assign sort_cmd.load   = (state == COUNT_RESULT);
	assign sort_cmd.update = (state == SETUP);
	assign sort_cmd.num    = num_q;
	assign merge_en        = (state == MERGE);
	assign code_valid      = (state == RESULT);

endmodule

// ==== design/huffman.sv ====
`timescale 1ns/1ps

module huffman #(
	parameter logic [7:0] SYM_BASE = 8'd1
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     gray_valid,
	input  logic [7:0]               gray_data,
	output logic                     cnt_valid,
	output huffman_sym_pkg::counts_t counts,
	output logic                     code_valid,
	output huffman_sym_pkg::codes_t  codes
);

	import huffman_sym_pkg::*;
	import huffman_ctrl_pkg::*;

	logic       count_en;
	logic       merge_en;
	logic       sorted;
	sort_cmd_t  sort_cmd;
	item_pair_t pair;

	huffman_control u_control (
		.clk        (clk),
		.rst        (rst),
		.gray_valid (gray_valid),
		.sorted     (sorted),
		.count_en   (count_en),
		.cnt_valid  (cnt_valid),
		.sort_cmd   (sort_cmd),
		.merge_en   (merge_en),
		.code_valid (code_valid)
	);

	symbol_counter #(
		.SYM_BASE (SYM_BASE)
	) u_counter (
		.clk       (clk),
		.rst       (rst),
		.count_en  (count_en),
		.gray_data (gray_data),
		.counts    (counts)
	);

	transposition_sorter u_sorter (
		.clk      (clk),
		.rst      (rst),
		.sort_cmd (sort_cmd),
		.counts   (counts),
		.sorted   (sorted),
		.pair     (pair)
	);

	code_builder u_builder (
		.clk      (clk),
		.rst      (rst),
		.merge_en (merge_en),
		.pair     (pair),
		.codes    (codes)
	);

endmodule

// ==== testbench/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen #(
	parameter int PERIOD_NS = 4
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	always #(PERIOD_NS / 2.0) clk = ~clk;

endmodule

// ==== testbench/huffman_assert.sv ====
`timescale 1ns/1ps

module huffman_assert (
	input logic                    clk,
	input logic                    rst,
	input logic                    cnt_valid,
	input logic                    code_valid,
	input huffman_sym_pkg::codes_t codes
);

	import huffman_sym_pkg::*;

	// Read by the testbench for its summary
	int fail_count;

	// A mask is 0..01..1 when adding one clears every set bit
	function automatic logic masks_contiguous(input codes_t c);
		logic ok;
		ok = 1'b1;
		for (int j = 0; j < NUM_SYMBOLS; j++) begin
			if ((c[j].mask & (c[j].mask + 8'd1)) != 8'd0) begin
				ok = 1'b0;
			end
		end
		return ok;
	endfunction

	valid_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(cnt_valid && code_valid)) else begin
		fail_count++;
		$error("cnt_valid and code_valid high in the same cycle");
	end

	cnt_pulse: assert property (@(posedge clk) disable iff (rst)
		cnt_valid |=> !cnt_valid) else begin
		fail_count++;
		$error("cnt_valid held longer than one cycle");
	end

	code_pulse: assert property (@(posedge clk) disable iff (rst)
		code_valid |=> !code_valid) else begin
		fail_count++;
		$error("code_valid held longer than one cycle");
	end

	mask_shape: assert property (@(posedge clk) disable iff (rst)
		code_valid |-> masks_contiguous(codes)) else begin
		fail_count++;
		$error("a code mask is not a run of ones from bit 0");
	end

endmodule

// ==== testbench/tb_huffman.sv ====
`timescale 1ns/1ps

module tb_huffman;

	import huffman_sym_pkg::*;

	localparam logic [7:0] SYM_BASE   = 8'd1;
	localparam int         NUM_RANDOM = 10;
	localparam int         NUM_TIED   = 4;
	localparam int         NO_SYM_LEN = 40;

	logic       clk;
	logic       rst;
	logic       gray_valid;
	logic [7:0] gray_data;
	logic       cnt_valid;
	logic       code_valid;
	counts_t    counts;
	codes_t     codes;

	int         seed;
	logic [7:0] frame_q[$];
	counts_t    exp_counts;
	bit         pending;
	int         cnt_seen;
	int         code_seen;
	int         value_errors;
	int         proto_errors;
	int         cycle_count;
	int         cycle_limit;

	// Row per tied frame, column i counts symbol i+1
	int tie_counts [NUM_TIED][NUM_SYMBOLS] = '{
		'{5, 5, 5, 5, 5, 5},
		'{3, 3, 2, 2, 1, 1},
		'{1, 2, 3, 4, 5, 6},
		'{0, 7, 0, 7, 0, 1}
	};

	clk_gen u_clk (.clk(clk));

	huffman #(.SYM_BASE(SYM_BASE)) dut (.*);

	bind huffman huffman_assert u_assert (.*);

	function automatic counts_t histogram();
		counts_t h;
		int      idx;
		h = '0;
		foreach (frame_q[i]) begin
			idx = int'(frame_q[i]) - int'(SYM_BASE);
			if (idx >= 0 && idx < NUM_SYMBOLS) begin
				h[idx] += 8'd1;
			end
		end
		return h;
	endfunction

	// Stable descending sort, then merge the last two items until one is left
	function automatic codes_t ref_codes(input counts_t c);
		int       cnt [NUM_SYMBOLS];
		sym_set_t members [NUM_SYMBOLS];
		int       code_len [NUM_SYMBOLS];
		int       t_cnt;
		sym_set_t t_members;
		codes_t   r;
		r = '0;
		for (int i = 0; i < NUM_SYMBOLS; i++) begin
			cnt[i]      = int'(c[i]);
			members[i]  = sym_set_t'(1 << i);
			code_len[i] = 0;
		end
		for (int n = NUM_SYMBOLS; n > 1; n--) begin
			for (int i = 1; i < n; i++) begin
				for (int j = i; j > 0; j--) begin
					if (cnt[j-1] < cnt[j]) begin
						t_cnt        = cnt[j];
						t_members    = members[j];
						cnt[j]       = cnt[j-1];
						members[j]   = members[j-1];
						cnt[j-1]     = t_cnt;
						members[j-1] = t_members;
					end
				end
			end
			// Last item gets a 1, second-to-last a 0
			for (int s = 0; s < NUM_SYMBOLS; s++) begin
				if (members[n-1][s]) begin
					r[s].hc[code_len[s]] = 1'b1;
				end
				if (members[n-2][s] || members[n-1][s]) begin
					code_len[s]++;
					r[s].mask = 8'((1 << code_len[s]) - 1);
				end
			end
			cnt[n-2]     = (cnt[n-2] + cnt[n-1]) % 256;
			members[n-2] = members[n-2] | members[n-1];
		end
		return r;
	endfunction

	task automatic fill_random(input int len, input int off_pct);
		frame_q.delete();
		repeat (len) begin
			if ($unsigned($random(seed)) % 100 < off_pct) begin
				// Offsets 6 to 255 from the base are never symbols
				frame_q.push_back(SYM_BASE + 8'd6 + 8'($unsigned($random(seed)) % 250));
			end else begin
				frame_q.push_back(SYM_BASE + 8'($unsigned($random(seed)) % 6));
			end
		end
	endtask

	// Symbols interleaved round by round
	task automatic fill_counts(input int row);
		frame_q.delete();
		for (int r = 0; r < 8; r++) begin
			for (int s = 0; s < NUM_SYMBOLS; s++) begin
				if (r < tie_counts[row][s]) begin
					frame_q.push_back(SYM_BASE + 8'(s));
				end
			end
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		rst        <= 1'b1;
		gray_valid <= 1'b0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		assert (!cnt_valid && !code_valid && counts == '0 && codes == '0) else begin
			value_errors++;
			$display("[FAIL] %0t: outputs not cleared after reset", $time);
		end
	endtask

	task automatic run_frame();
		int cnt_before;
		int code_before;
		cnt_before  = cnt_seen;
		code_before = code_seen;
		apply_reset();
		exp_counts = histogram();
		foreach (frame_q[i]) begin
			@(posedge clk);
			gray_valid <= 1'b1;
			gray_data  <= frame_q[i];
		end
		@(posedge clk);
		gray_valid <= 1'b0;
		gray_data  <= 8'h00;
		while (code_seen == code_before) begin
			@(posedge clk);
		end
		// Room for a stray extra pulse
		repeat (8) @(posedge clk);
		assert (cnt_seen - cnt_before == 1 && code_seen - code_before == 1) else begin
			proto_errors++;
			$display("Error: frame gave %0d cnt_valid and %0d code_valid pulses, not one each",
				cnt_seen - cnt_before, code_seen - code_before);
		end
	endtask

	// Compare on the falling edge, away from register updates
	always @(negedge clk) begin
		if (!rst && cnt_valid) begin
			cnt_seen++;
			assert (!pending) else begin
				proto_errors++;
				$display("Error: cnt_valid at %0t came before the previous code_valid", $time);
			end
			assert (counts == exp_counts) else begin
				value_errors++;
				$display("[FAIL] %0t: counts %h, expected %h", $time, counts, exp_counts);
			end
			pending = 1'b1;
		end
		if (!rst && code_valid) begin
			code_seen++;
			assert (pending) else begin
				proto_errors++;
				$display("Error: code_valid at %0t without a cnt_valid before it", $time);
			end
			assert (codes == ref_codes(exp_counts)) else begin
				value_errors++;
				$display("[FAIL] %0t: codes %h, expected %h", $time, codes,
					ref_codes(exp_counts));
			end
			pending = 1'b0;
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("Error: no result within %0d cycles, run stopped", cycle_limit);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	initial begin
		int lens [NUM_RANDOM];
		seed       = 32'h9399_dc08;
		rst        = 1'b1;
		gray_valid = 1'b0;
		gray_data  = 8'h00;
		// 100 cycles per frame value and 200 per frame
		cycle_limit = 200 + 100 * NO_SYM_LEN;
		for (int f = 0; f < NUM_RANDOM; f++) begin
			lens[f] = 20 + $unsigned($random(seed)) % 181;
			cycle_limit += 200 + 100 * lens[f];
		end
		for (int t = 0; t < NUM_TIED; t++) begin
			cycle_limit += 200;
			for (int s = 0; s < NUM_SYMBOLS; s++) begin
				cycle_limit += 100 * tie_counts[t][s];
			end
		end
		for (int t = 0; t < NUM_TIED; t++) begin
			fill_counts(t);
			run_frame();
		end
		// No symbols at all, so every count stays zero
		fill_random(NO_SYM_LEN, 100);
		run_frame();
		for (int f = 0; f < NUM_RANDOM; f++) begin
			fill_random(lens[f], (f % 2) * 30);
			run_frame();
		end
		$display("Errors: %0d value, %0d protocol, %0d assertion",
			value_errors, proto_errors, dut.u_assert.fail_count);
		if (value_errors + proto_errors + dut.u_assert.fail_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// ==== huffman.f ====
design/huffman_sym_pkg.sv
design/huffman_ctrl_pkg.sv
design/symbol_counter.sv
design/transposition_sorter.sv
design/code_builder.sv
design/huffman_control.sv
design/huffman.sv
testbench/clk_gen.sv
testbench/huffman_assert.sv
testbench/tb_huffman.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_huffman
FILELIST  = huffman.f
RUN_ARGS  = +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir
